// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fdivsqrt
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/fdivsqrt_iter.sv
module fdivsqrt_iter import fdivsqrt_pkg::*; (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  logic                    div_start_i,
   input  logic                    sqrt_start_i,
   input  logic                    kill_i,
   input  divsqrt_op_e             op_i,
   input  logic                    special_i,   // Bypass the recurrence
   input  logic [PREC_BITS-1:0]    mant_a_i,    // Normalized, MSB set
   input  logic [PREC_BITS-1:0]    mant_b_i,
   input  logic signed [EXP_W-1:0] exp_a_i,
   input  logic signed [EXP_W-1:0] exp_b_i,
   output logic                    accept_o,
   output logic                    in_ready_o,
   output logic                    done_o,
   output logic                    finish_o,
   output logic [RES_W-1:0]        res_mant_o,  // Bit 0 carries sticky
   output logic signed [EXP_W-1:0] res_exp_o
);

   ctrl_state_e             state_q;
   logic [CNT_W-1:0]        cnt_q;          // 0 is the setup cycle
   logic [RES_W+1:0]        rem_q, rem_d;   // Partial remainder
   logic [RES_W-1:0]        res_q, res_d;   // Quotient/root bits, MSB first
   logic [PREC_BITS+1:0]    rad_q, rad_d;   // Radicand pairs not yet consumed
   logic signed [EXP_W-1:0] exp_q, exp_d;
   logic signed [EXP_W-1:0] exp_unb;        // Unbiased sqrt exponent
   logic signed [EXP_W-1:0] exp_even;
   logic                    exp_odd;
   logic [RES_W+1:0]        divisor;
   logic [RES_W+1:0]        rem_sh;         // Remainder with next pair shifted in
   logic [RES_W+1:0]        trial;          // 4*root + 1

   assign in_ready_o = (state_q == IDLE);
   assign accept_o   = in_ready_o & (div_start_i | sqrt_start_i);
   assign finish_o   = (state_q == ROUND);
   assign done_o     = finish_o & ~kill_i;  // Killed result is dropped

   // ------------------------------------------------------------------------
   // Control FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               cnt_q <= '0;
               if (accept_o) state_q <= ITER;
            end
            ITER: begin
               cnt_q <= cnt_q + 1'b1;
               if (kill_i) state_q <= IDLE;
               else if (special_i || cnt_q == CNT_W'(ITER_CYCLES)) state_q <= ROUND;
            end
            ROUND:   state_q <= IDLE;  // One cycle, also on kill
            default: state_q <= IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Recurrence datapath
   // ------------------------------------------------------------------------
   assign exp_unb  = exp_a_i - BIAS;
   assign exp_odd  = exp_unb[0];
   assign exp_even = {exp_unb[EXP_W-1:1], 1'b0};            // Round down to even
   assign divisor  = (RES_W+2)'(mant_b_i);
   assign rem_sh   = {rem_q[RES_W-1:0], rad_q[PREC_BITS+1 -: 2]};
   assign trial    = {res_q, 2'b01};

   always_comb begin : recurrence
      rem_d = rem_q;
      res_d = res_q;
      rad_d = rad_q;
      exp_d = exp_q;
      if (cnt_q == '0) begin                                 // Setup
         res_d = '0;
         if (op_i == OP_DIV) begin
            rem_d = (RES_W+2)'(mant_a_i);
            exp_d = exp_a_i - exp_b_i + BIAS;
         end else begin
            rem_d = '0;
            rad_d = exp_odd ? {mant_a_i, 2'b00} : {1'b0, mant_a_i, 1'b0}; // Odd: x2
            exp_d = (exp_even >>> 1) + BIAS;
         end
      end else if (op_i == OP_DIV) begin                     // Restoring division
         if (rem_q >= divisor) begin
            rem_d = (rem_q - divisor) << 1;
            res_d = {res_q[RES_W-2:0], 1'b1};
         end else begin
            rem_d = rem_q << 1;
            res_d = {res_q[RES_W-2:0], 1'b0};
         end
      end else begin                                         // Digit-by-digit root
         if (rem_sh >= trial) begin
            rem_d = rem_sh - trial;
            res_d = {res_q[RES_W-2:0], 1'b1};
         end else begin
            rem_d = rem_sh;
            res_d = {res_q[RES_W-2:0], 1'b0};
         end
         rad_d = rad_q << 2;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ITER) begin
         rem_q <= rem_d;
         res_q <= res_d;
         rad_q <= rad_d;
         exp_q <= exp_d;
      end
   end

   assign res_mant_o = {res_q[RES_W-1:1], res_q[0] | (|rem_q)}; // Nonzero rem is inexact
   assign res_exp_o  = exp_q;

endmodule

// File: design/fdivsqrt_pkg.sv
package fdivsqrt_pkg;

   // ------------------------------------------------------------------------
   // Binary32 format
   // ------------------------------------------------------------------------
   localparam int EXP_BITS  = 8;              // Exponent field
   localparam int MAN_BITS  = 23;             // Stored mantissa field
   localparam int PREC_BITS = MAN_BITS + 1;   // Significand incl. hidden bit

   // ------------------------------------------------------------------------
   // Internal widths and counts
   // ------------------------------------------------------------------------
   localparam int EXP_W       = EXP_BITS + 2;  // Signed, room for under/overflow
   localparam int RES_W       = PREC_BITS + 4; // Result significand plus rounding bits
   localparam int ITER_CYCLES = RES_W;         // One quotient/root bit per cycle
   localparam int LZC_W       = $clog2(PREC_BITS);
   localparam int CNT_W       = $clog2(ITER_CYCLES + 1);
   localparam int SHIFT_W     = $clog2(RES_W + 1);

   // Exponent constants in the signed internal width
   localparam logic signed [EXP_W-1:0] BIAS    = EXP_W'(127);
   localparam logic signed [EXP_W-1:0] EXP_INF = EXP_W'((2 ** EXP_BITS) - 1);

   localparam logic [31:0] QNAN = 32'h7FC0_0000; // Canonical quiet NaN

   // ------------------------------------------------------------------------
   // Types
   // ------------------------------------------------------------------------
   // IEEE rounding modes, encoding as in the RISC-V frm field
   typedef enum logic [2:0] {
      RNE = 3'b000,  // Nearest, ties to even
      RTZ = 3'b001,  // Toward zero
      RDN = 3'b010,  // Toward minus infinity
      RUP = 3'b011   // Toward plus infinity
   } roundmode_e;

   typedef enum logic {
      OP_DIV  = 1'b0,
      OP_SQRT = 1'b1
   } divsqrt_op_e;

   // Iterator control
   typedef enum logic [1:0] {
      IDLE  = 2'b00,  // Waiting for start
      ITER  = 2'b01,  // Setup cycle plus recurrence
      ROUND = 2'b10   // Result valid for one cycle
   } ctrl_state_e;

   // IEEE exception flags
   typedef struct packed {
      logic NV;  // Invalid operation
      logic DZ;  // Division by zero
      logic OF;  // Overflow
      logic UF;  // Underflow
      logic NX;  // Inexact
   } status_t;

endpackage

// File: design/fdivsqrt_round.sv
module fdivsqrt_round import fdivsqrt_pkg::*; (
   input  logic                    special_i,
   input  logic [31:0]             special_result_i,
   input  status_t                 special_status_i,
   input  logic                    sign_i,
   input  roundmode_e              rnd_mode_i,
   input  logic [RES_W-1:0]        res_mant_i,  // 1.x or 0.1x, sticky in LSB
   input  logic signed [EXP_W-1:0] res_exp_i,
   output logic [31:0]             result_o,
   output status_t                 status_o
);

   logic                            msb_zero;
   logic [RES_W-1:0]                norm_mant;
   logic signed [EXP_W-1:0]         norm_exp;
   logic signed [EXP_W-1:0]         amt;          // 1 - exp, subnormal shift
   logic [SHIFT_W-1:0]              shamt;
   logic [RES_W-1:0]                fin_mant;
   logic [RES_W-1:0]                out_bits;     // Shifted past the LSB
   logic signed [EXP_W-1:0]         fin_exp;
   logic                            of_before, of_after, uf_after;
   logic [EXP_BITS+MAN_BITS-1:0]    pre_abs, rounded_abs;
   logic                            round_bit, sticky_bit, round_up;
   logic [31:0]                     reg_result;
   status_t                         reg_status;

   // ------------------------------------------------------------------------
   // Pre-round shifts
   // ------------------------------------------------------------------------
   assign msb_zero  = ~res_mant_i[RES_W-1];
   assign norm_mant = msb_zero ? res_mant_i << 1 : res_mant_i;
   assign norm_exp  = res_exp_i - EXP_W'(msb_zero);
   assign amt       = EXP_W'(1) - norm_exp;

   always_comb begin : right_shift_amount
      if (norm_exp > 0) shamt = '0;                 // Normal, no shift
      else if (amt >= RES_W) shamt = SHIFT_W'(RES_W); // All into sticky
      else shamt = amt[SHIFT_W-1:0];
   end

   assign {fin_mant, out_bits} = {norm_mant, {RES_W{1'b0}}} >> shamt;
   assign fin_exp   = (norm_exp > 0) ? norm_exp : '0;  // Subnormal field is zero
   assign of_before = (fin_exp >= EXP_INF);

   // Overflow is rounded from the largest finite value with R and S set
   assign pre_abs    = of_before ? {EXP_BITS'(EXP_INF - 1), {MAN_BITS{1'b1}}}
                                 : {fin_exp[EXP_BITS-1:0], fin_mant[RES_W-2 -: MAN_BITS]};
   assign round_bit  = fin_mant[RES_W-2-MAN_BITS] | of_before;
   assign sticky_bit = (|fin_mant[RES_W-3-MAN_BITS:0]) | (|out_bits) | of_before;

   // ------------------------------------------------------------------------
   // Rounding
   // ------------------------------------------------------------------------
   always_comb begin : round_decision
      case (rnd_mode_i)
         RNE:     round_up = round_bit & (sticky_bit | pre_abs[0]); // Ties to even
         RTZ:     round_up = 1'b0;
         RDN:     round_up = (round_bit | sticky_bit) & sign_i;
         RUP:     round_up = (round_bit | sticky_bit) & ~sign_i;
         default: round_up = 1'b0;
      endcase
   end

   // Carry may enter the exponent, e.g. subnormal to normal or max to inf
   assign rounded_abs = pre_abs + (EXP_BITS+MAN_BITS)'(round_up);
   assign of_after    = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1);
   assign uf_after    = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0);

   // ------------------------------------------------------------------------
   // Flags and result select
   // ------------------------------------------------------------------------
   assign reg_result    = {sign_i, rounded_abs};
   assign reg_status.NV = 1'b0;                        // Invalid cases are all special
   assign reg_status.DZ = 1'b0;
   assign reg_status.OF = of_before | of_after;
   assign reg_status.UF = uf_after & (round_bit | sticky_bit); // Tiny and inexact
   assign reg_status.NX = round_bit | sticky_bit;      // Includes overflow

   assign result_o = special_i ? special_result_i : reg_result;
   assign status_o = special_i ? special_status_i : reg_status;

endmodule

// File: design/fdivsqrt_top.sv
module fdivsqrt_top import fdivsqrt_pkg::*; (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic [31:0] operand_a_i,
   input  logic [31:0] operand_b_i,     // Ignored for square root
   input  logic        div_start_i,
   input  logic        sqrt_start_i,
   input  roundmode_e  rnd_mode_i,
   input  logic        kill_i,
   output logic [31:0] result_o,        // Valid while done_o is high
   output status_t     status_o,
   output logic        in_ready_o,
   output logic        done_o
);

   logic                    accept, sqrt_sel, sign, special;
   divsqrt_op_e             op;
   roundmode_e              rnd_mode;
   logic [31:0]             special_result;
   status_t                 special_status;
   logic [PREC_BITS-1:0]    mant_a, mant_b;
   logic signed [EXP_W-1:0] exp_a, exp_b, res_exp;
   logic [RES_W-1:0]        res_mant;

   assign sqrt_sel = sqrt_start_i & ~div_start_i; // Division wins a tie

   fdivsqrt_unpack i_unpack (
      .clk_i, .arst_n_i, .operand_a_i, .operand_b_i, .sqrt_start_i (sqrt_sel),
      .rnd_mode_i, .accept_i (accept), .op_o (op), .rnd_mode_o (rnd_mode), .sign_o (sign),
      .special_o (special), .special_result_o (special_result),
      .special_status_o (special_status), .mant_a_o (mant_a), .mant_b_o (mant_b),
      .exp_a_o (exp_a), .exp_b_o (exp_b));

   fdivsqrt_iter i_iter (
      .clk_i, .arst_n_i, .div_start_i, .sqrt_start_i, .kill_i, .op_i (op),
      .special_i (special), .mant_a_i (mant_a), .mant_b_i (mant_b), .exp_a_i (exp_a),
      .exp_b_i (exp_b), .accept_o (accept), .in_ready_o, .done_o,
      .finish_o (), .res_mant_o (res_mant), .res_exp_o (res_exp)); // done_o covers finish

   fdivsqrt_round i_round (
      .special_i (special), .special_result_i (special_result),
      .special_status_i (special_status), .sign_i (sign), .rnd_mode_i (rnd_mode),
      .res_mant_i (res_mant), .res_exp_i (res_exp), .result_o, .status_o);

endmodule

// File: design/fdivsqrt_unpack.sv
module fdivsqrt_unpack import fdivsqrt_pkg::*; (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  logic [31:0]             operand_a_i,
   input  logic [31:0]             operand_b_i,
   input  logic                    sqrt_start_i,     // Square root selected, B unused
   input  roundmode_e              rnd_mode_i,
   input  logic                    accept_i,         // New operation taken this cycle
   output divsqrt_op_e             op_o,
   output roundmode_e              rnd_mode_o,
   output logic                    sign_o,
   output logic                    special_o,
   output logic [31:0]             special_result_o,
   output status_t                 special_status_o,
   output logic [PREC_BITS-1:0]    mant_a_o,
   output logic [PREC_BITS-1:0]    mant_b_o,
   output logic signed [EXP_W-1:0] exp_a_o,
   output logic signed [EXP_W-1:0] exp_b_o
);

   // Leading zeros, highest set bit wins since the loop runs upward
   function automatic logic [LZC_W-1:0] lzc(input logic [PREC_BITS-1:0] m);
      logic [LZC_W-1:0] cnt;
      cnt = '0;
      for (int i = 0; i < PREC_BITS; i++) begin
         if (m[i]) cnt = LZC_W'(PREC_BITS - 1 - i);
      end
      return cnt;
   endfunction

   logic [1:0][31:0]          ops;      // [0] = A, [1] = B
   logic [1:0]                sign, is_zero, is_sub, is_inf, is_nan, is_snan;
   logic [1:0][EXP_BITS-1:0]  exp_f;
   logic [1:0][MAN_BITS-1:0]  man_f;
   logic [1:0][PREC_BITS-1:0] mant_ext;  // With hidden bit
   logic [1:0][LZC_W-1:0]     lz;
   logic                      res_sign;
   logic                      spec;
   logic [31:0]               spec_res;
   status_t                   spec_st;

   assign ops = {operand_b_i, operand_a_i};

   // ------------------------------------------------------------------------
   // Classification and normalization
   // ------------------------------------------------------------------------
   always_comb begin : classify
      for (int i = 0; i < 2; i++) begin
         sign[i]     = ops[i][31];
         exp_f[i]    = ops[i][MAN_BITS +: EXP_BITS];
         man_f[i]    = ops[i][MAN_BITS-1:0];
         is_zero[i]  = (exp_f[i] == '0) && (man_f[i] == '0);
         is_sub[i]   = (exp_f[i] == '0) && (man_f[i] != '0);
         is_inf[i]   = (exp_f[i] == '1) && (man_f[i] == '0);
         is_nan[i]   = (exp_f[i] == '1) && (man_f[i] != '0);
         is_snan[i]  = is_nan[i] & ~man_f[i][MAN_BITS-1]; // Quiet bit clear
         mant_ext[i] = {|exp_f[i], man_f[i]};
         lz[i]       = lzc(mant_ext[i]);
      end
      if (sqrt_start_i) begin // B acts as a plain normal number
         is_zero[1] = 1'b0;
         is_sub[1]  = 1'b0;
         is_inf[1]  = 1'b0;
         is_nan[1]  = 1'b0;
         is_snan[1] = 1'b0;
      end
   end

   assign res_sign = sqrt_start_i ? sign[0] : sign[0] ^ sign[1];

   // ------------------------------------------------------------------------
   // Special cases, in priority order
   // ------------------------------------------------------------------------
   always_comb begin : special_case
      spec     = 1'b1;
      spec_res = QNAN;
      spec_st  = '0;
      if (|is_nan) begin
         spec_st.NV = |is_snan;                          // Only sNaN is invalid
      end else if (is_zero[0] && is_zero[1]) begin
         spec_st.NV = 1'b1;                              // 0/0
      end else if (is_zero[1]) begin
         spec_res   = {res_sign, {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
         spec_st.DZ = ~is_inf[0];                        // inf/0 is exact
      end else if (is_zero[0]) begin
         spec_res = {res_sign, 31'd0};                   // 0/x, sqrt(+-0)
      end else if (sqrt_start_i && sign[0]) begin
         spec_st.NV = 1'b1;                              // Negative radicand
      end else if (is_inf[0] && is_inf[1]) begin
         spec_st.NV = 1'b1;                              // inf/inf
      end else if (is_inf[0]) begin
         spec_res = {res_sign, {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end else if (is_inf[1]) begin
         spec_res = {res_sign, 31'd0};                   // x/inf
      end else begin
         spec = 1'b0;                                    // Regular path
      end
   end

   // Control part of the operation
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         op_o       <= OP_DIV;
         rnd_mode_o <= RNE;
         special_o  <= 1'b0;
      end else if (accept_i) begin
         op_o       <= sqrt_start_i ? OP_SQRT : OP_DIV;
         rnd_mode_o <= rnd_mode_i;
         special_o  <= spec;
      end
   end

   // Payload, held for the whole operation
   always_ff @(posedge clk_i) begin
      if (accept_i) begin
         sign_o           <= res_sign;
         special_result_o <= spec_res;
         special_status_o <= spec_st;
         mant_a_o         <= mant_ext[0] << lz[0];
         mant_b_o         <= mant_ext[1] << lz[1];
         exp_a_o <= EXP_W'(exp_f[0]) - EXP_W'(lz[0]) + EXP_W'(is_sub[0]); // 1 - lz if sub
         exp_b_o <= EXP_W'(exp_f[1]) - EXP_W'(lz[1]) + EXP_W'(is_sub[1]);
      end
   end

endmodule

// File: tests/tb_fdivsqrt.sv
module tb_fdivsqrt import fdivsqrt_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD  = 10;
   localparam int N_PAIRS     = 16;                    // Exact divisions, each in four modes
   localparam int N_ROOTS     = 16;                    // Exact square roots
   localparam int NUM_OPS     = N_PAIRS * 4 + N_ROOTS + 21; // Plus directed and control ops
   localparam int WDOG_CYCLES = NUM_OPS * 40 + 200;
   localparam int LAT_REG     = 30;                    // Accept edge to done, regular op
   localparam int LAT_SPECIAL = 2;                     // Special case skips the recurrence
   localparam int OP_LIMIT    = 100;                   // Per operation wait limit

   logic        clk, arst_n;
   logic [31:0] operand_a, operand_b;
   logic        div_start, sqrt_start, kill;
   roundmode_e  rnd_mode;
   logic [31:0] result;
   status_t     status;
   logic        in_ready, done;

   logic [31:0] exp_result;        // Expected values for the op in flight
   status_t     exp_status;
   logic        done_expected;     // Low while a killed op must stay silent
   int          value_errors, ctrl_errors;
   int          seed = 16733;

   fdivsqrt_top DUT (
      .clk_i (clk), .arst_n_i (arst_n), .operand_a_i (operand_a), .operand_b_i (operand_b),
      .div_start_i (div_start), .sqrt_start_i (sqrt_start), .rnd_mode_i (rnd_mode),
      .kill_i (kill), .result_o (result), .status_o (status), .in_ready_o (in_ready),
      .done_o (done));

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Checks at every done pulse
   // ------------------------------------------------------------------------
   assert property (@(posedge clk) disable iff (!arst_n) done |-> result == exp_result)
      else begin
         value_errors++;
         $display("CHECK FAILED result_o: got 0x%08h, expected 0x%08h", result, exp_result);
      end

   assert property (@(posedge clk) disable iff (!arst_n) done |-> status == exp_status)
      else begin
         value_errors++;
         $display("CHECK FAILED status_o: got 0x%02h, expected 0x%02h", status, exp_status);
      end

   assert property (@(posedge clk) disable iff (!arst_n) done |-> done_expected)
      else begin
         ctrl_errors++;
         $display("done_o pulsed for an operation that was killed");
      end

   // Exact FP32 encoding of a nonzero integer below 2**24
   function automatic logic [31:0] int_to_fp32(input logic sign, input logic [23:0] n);
      int          k;
      logic [31:0] m;
      k = 0;
      for (int i = 0; i < 24; i++) begin
         if (n[i]) k = i;                              // Position of the leading one
      end
      m = 32'(n) << (23 - k);
      return {sign, 8'(127 + k), m[22:0]};
   endfunction

   function automatic status_t make_status(input logic nv, dz, of, uf, nx);
      return {nv, dz, of, uf, nx};
   endfunction

   task automatic compare_bit(input string name, input logic got, input logic want);
      assert (got === want) else begin
         ctrl_errors++;
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
      end
   endtask

   // One operation, entered and left 1 ns after a rising edge
   task automatic run_op(input logic is_sqrt, input logic [31:0] a, input logic [31:0] b,
                         input roundmode_e rm, input logic [31:0] want_res,
                         input status_t want_st, input int want_lat, input logic poke_busy);
      int lat;
      while (!in_ready) begin
         @(posedge clk);
         #1;
      end
      exp_result = want_res;
      exp_status = want_st;
      operand_a  = a;
      operand_b  = b;
      rnd_mode   = rm;
      div_start  = ~is_sqrt;
      sqrt_start = is_sqrt;
      @(posedge clk);                                  // Accept edge
      #1;
      div_start  = 1'b0;
      sqrt_start = 1'b0;
      operand_a  = 32'hDEAD_BEEF;                      // Unit works from its own copy now
      compare_bit("in_ready_o", in_ready, 1'b0);
      lat = 1;
      while (!done && lat < OP_LIMIT) begin
         div_start = poke_busy && (lat == 10);         // Start while busy, must be ignored
         @(posedge clk);
         #1;
         lat++;
      end
      div_start = 1'b0;
      if (!done) begin
         ctrl_errors++;
         $display("No done_o within %0d cycles of accept", OP_LIMIT);
      end else begin
         assert (lat == want_lat) else begin
            ctrl_errors++;
            $display("done_o came %0d cycles after accept, expected %0d", lat, want_lat);
         end
         @(posedge clk);
         #1;
         compare_bit("done_o", done, 1'b0);            // Single cycle pulse
         compare_bit("in_ready_o", in_ready, 1'b1);
      end
   endtask

   task automatic kill_during_iteration();
      done_expected = 1'b0;
      operand_a     = 32'h3F80_0000;
      operand_b     = 32'h4040_0000;
      div_start     = 1'b1;
      @(posedge clk);
      #1;
      div_start = 1'b0;
      repeat (5) begin
         @(posedge clk);
         #1;
      end
      kill = 1'b1;
      @(posedge clk);
      #1;
      kill = 1'b0;
      compare_bit("in_ready_o", in_ready, 1'b1);       // Back to idle at once
      repeat (35) begin                                // Past the normal done point
         @(posedge clk);
         #1;
      end
      done_expected = 1'b1;
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial begin : stimulus
      logic [23:0] p, q;
      logic        sa, sb;
      roundmode_e  modes [4];
      modes         = '{RNE, RTZ, RDN, RUP};
      arst_n        = 1'b0;
      operand_a     = '0;
      operand_b     = '0;
      div_start     = 1'b0;
      sqrt_start    = 1'b0;
      kill          = 1'b0;
      rnd_mode      = RNE;
      exp_result    = '0;
      exp_status    = '0;
      done_expected = 1'b1;
      value_errors  = 0;
      ctrl_errors   = 0;
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      compare_bit("in_ready_o", in_ready, 1'b1);
      compare_bit("done_o", done, 1'b0);

      // Exact quotients, no rounding in any mode
      for (int i = 0; i < N_PAIRS; i++) begin
         p  = 24'(1 + $unsigned($random(seed)) % 4095);
         q  = 24'(1 + $unsigned($random(seed)) % 4095);
         sa = 1'($random(seed));
         sb = 1'($random(seed));
         for (int m = 0; m < 4; m++) begin
            run_op(1'b0, int_to_fp32(sa, p * q), int_to_fp32(sb, q), modes[m],
                   int_to_fp32(sa ^ sb, p), '0, LAT_REG, 1'b0);
         end
      end
      run_op(1'b0, 32'h0080_0000, 32'h4000_0000, RNE, 32'h0040_0000, '0, LAT_REG, 1'b0);
      run_op(1'b0, 32'h0040_0000, 32'h3F80_0000, RNE, 32'h0040_0000, '0, LAT_REG, 1'b0);

      for (int i = 0; i < N_ROOTS; i++) begin        // Perfect squares
         p = 24'(1 + $unsigned($random(seed)) % 4095);
         run_op(1'b1, int_to_fp32(1'b0, p * p), 32'h3F80_0000, RNE,
                int_to_fp32(1'b0, p), '0, LAT_REG, 1'b0);
      end

      // Special cases
      run_op(1'b0, 32'h3F80_0000, 32'h0, RNE, 32'h7F80_0000,
             make_status(0, 1, 0, 0, 0), LAT_SPECIAL, 1'b0);
      run_op(1'b0, 32'h0, 32'h0, RNE, QNAN, make_status(1, 0, 0, 0, 0), LAT_SPECIAL, 1'b0);
      run_op(1'b1, 32'hC080_0000, 32'h3F80_0000, RNE, QNAN,
             make_status(1, 0, 0, 0, 0), LAT_SPECIAL, 1'b0);
      run_op(1'b0, 32'h7F80_0001, 32'h3F80_0000, RNE, QNAN,
             make_status(1, 0, 0, 0, 0), LAT_SPECIAL, 1'b0);   // Signalling NaN
      run_op(1'b0, 32'h7FC0_0000, 32'h3F80_0000, RNE, QNAN, '0, LAT_SPECIAL, 1'b0);
      run_op(1'b0, 32'hFF80_0000, 32'h4000_0000, RNE, 32'hFF80_0000, '0, LAT_SPECIAL, 1'b0);
      run_op(1'b0, 32'h4040_0000, 32'h7F80_0000, RNE, 32'h0000_0000, '0, LAT_SPECIAL, 1'b0);

      // 1/3 and -1/3 in every mode
      run_op(1'b0, 32'h3F80_0000, 32'h4040_0000, RNE, 32'h3EAA_AAAB, 5'b00001, LAT_REG, 1'b0);
      run_op(1'b0, 32'h3F80_0000, 32'h4040_0000, RTZ, 32'h3EAA_AAAA, 5'b00001, LAT_REG, 1'b0);
      run_op(1'b0, 32'h3F80_0000, 32'h4040_0000, RDN, 32'h3EAA_AAAA, 5'b00001, LAT_REG, 1'b0);
      run_op(1'b0, 32'h3F80_0000, 32'h4040_0000, RUP, 32'h3EAA_AAAB, 5'b00001, LAT_REG, 1'b0);
      run_op(1'b0, 32'hBF80_0000, 32'h4040_0000, RNE, 32'hBEAA_AAAB, 5'b00001, LAT_REG, 1'b0);
      run_op(1'b0, 32'hBF80_0000, 32'h4040_0000, RTZ, 32'hBEAA_AAAA, 5'b00001, LAT_REG, 1'b0);
      run_op(1'b0, 32'hBF80_0000, 32'h4040_0000, RDN, 32'hBEAA_AAAB, 5'b00001, LAT_REG, 1'b0);
      run_op(1'b0, 32'hBF80_0000, 32'h4040_0000, RUP, 32'hBEAA_AAAA, 5'b00001, LAT_REG, 1'b0);

      // Largest finite over 0.5
      run_op(1'b0, 32'h7F7F_FFFF, 32'h3F00_0000, RNE, 32'h7F80_0000,
             make_status(0, 0, 1, 0, 1), LAT_REG, 1'b0);
      run_op(1'b0, 32'h7F7F_FFFF, 32'h3F00_0000, RTZ, 32'h7F7F_FFFF,
             make_status(0, 0, 1, 0, 1), LAT_REG, 1'b0);

      // Control
      run_op(1'b0, 32'h3F80_0000, 32'h4040_0000, RNE, 32'h3EAA_AAAB, 5'b00001, LAT_REG, 1'b1);
      kill_during_iteration();

      $display("Errors: %0d value, %0d control", value_errors, ctrl_errors);
      if (value_errors + ctrl_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      #(WDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: vlog.f
design/fdivsqrt_pkg.sv
design/fdivsqrt_unpack.sv
design/fdivsqrt_iter.sv
design/fdivsqrt_round.sv
design/fdivsqrt_top.sv
tests/tb_fdivsqrt.sv
